// ==== flist.f ====
+incdir+testbench
common/ldpc_alu_pkg.sv
ldpc/ldpc_lane.sv
ldpc/ldpc_simd_exec.sv
verilog/wb_issue_stage.sv
verilog/int_exec_stage.sv
verilog/result_stage.sv
verilog/ldpc_alu_top.sv
testbench/tb_ldpc_alu.sv

// ==== testbench/tb_ldpc_alu_tasks.svh ====
// Bus tasks, result checking, reference model and directed tests for the LDPC ALU
`ifndef TB_LDPC_ALU_TASKS_SVH
`define TB_LDPC_ALU_TASKS_SVH

// ------------------------------
// Failure reporting
// ------------------------------
task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
endtask

task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                           input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
endtask

// ------------------------------
// Wishbone classic master
// ------------------------------
// Called and returns at DRIVE_DELAY after a rising edge
task automatic bus_cycle(input logic we, input logic [ADDR_W-1:0] adr,
                         input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata,
                         output int cycles);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
    cycles = 0;
    do begin
        @(posedge clk);
        #(SAMPLE_DELAY);
        cycles++;
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    // Request stays up through the edge that takes the ack
    @(posedge clk);
    #(DRIVE_DELAY);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
endtask

task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [XLEN-1:0] data);
    logic [XLEN-1:0] unused;
    int              cycles;
    bus_cycle(1'b1, adr, data, unused, cycles);
endtask

task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [XLEN-1:0] data);
    int cycles;
    bus_cycle(1'b0, adr, '0, data, cycles);
endtask

// ------------------------------
// Reference model
// ------------------------------
function automatic logic [LANE_W-1:0] lane_model(input alu_op_e op,
                                                 input logic [LANE_W-1:0] a,
                                                 input logic [LANE_W-1:0] b);
    int                ai;
    int                bi;
    int                v;
    logic [LANE_W-1:0] r;
    ai = $signed(a);
    bi = $signed(b);
    v  = 0;
    case (op)
        LDPC_SUBSAT, LDPC_ADDSAT: begin
            v = (op == LDPC_SUBSAT) ? ai - bi : ai + bi;
            if (v > SAT_MAX) begin
                v = SAT_MAX;
            end else if (v < -SAT_MAX) begin
                v = -SAT_MAX;
            end
            r = v[LANE_W-1:0];
        end
        LDPC_SIGN: r = (ai < 0) ? 1 : 0;
        LDPC_ABS: begin
            v = (ai < 0) ? -ai : ai;
            r = v[LANE_W-1:0];
        end
        LDPC_MAX:   r = (ai >= bi) ? a : b;
        LDPC_MIN:   r = (ai >= bi) ? b : a;
        LDPC_EVAL:  r = (a == b) ? 8'hFF : 8'h00;
        LDPC_RSIGN: r = (bi >= 0) ? {a[LANE_W-1:1], ~a[0]} : a;
        LDPC_NMESS: begin
            v = (ai != 0) ? bi : -bi;
            r = v[LANE_W-1:0];
        end
        default: r = '0;
    endcase
    return r;
endfunction

function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    int              i;
    case (op)
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_AND:  r = a & b;
        OP_OR:   r = a | b;
        OP_XOR:  r = a ^ b;
        OP_SLTS: r = ($signed(a) < $signed(b)) ? 1 : 0;
        OP_SLTU: r = (a < b) ? 1 : 0;
        default: begin
            for (i = 0; i < LANES; i++) begin
                r[i*LANE_W +: LANE_W] = lane_model(op, a[i*LANE_W +: LANE_W],
                                                   b[i*LANE_W +: LANE_W]);
            end
        end
    endcase
    return r;
endfunction

// ------------------------------
// Operation helpers
// ------------------------------
task automatic run_op(input alu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                      output logic [XLEN-1:0] result);
    wb_write(ADDR_OPA, a);
    wb_write(ADDR_OPB, b);
    wb_write(ADDR_CMD, XLEN'(op));
    wb_read(ADDR_RESULT, result);
endtask

task automatic check_op(input alu_op_e op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, output logic [XLEN-1:0] result);
    run_op(op, a, b, result);
    check_value($sformatf("result %s", op.name()), result, alu_model(op, a, b));
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic idle_after_reset();
    logic [XLEN-1:0] d;
    repeat (10) begin
        @(posedge clk);
        #(SAMPLE_DELAY);
        check_value("wb_rsp.ack", XLEN'(wb_rsp.ack), '0);
    end
    #(DRIVE_DELAY - SAMPLE_DELAY);
    wb_read(ADDR_OPA, d);
    check_value("OPA after reset", d, '0);
    wb_read(ADDR_OPB, d);
    check_value("OPB after reset", d, '0);
endtask

task automatic operand_readback();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] d;
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    wb_write(ADDR_OPA, a);
    wb_write(ADDR_OPB, b);
    wb_read(ADDR_OPA, d);
    check_value("OPA readback", d, a);
    wb_read(ADDR_OPB, d);
    check_value("OPB readback", d, b);
    wb_read(ADDR_CMD, d);
    check_value("CMD readback", d, '0);
endtask

task automatic scalar_vectors();
    logic [XLEN-1:0] r;
    check_op(OP_ADD, 64'hFFFF_FFFF_FFFF_FFFF, 64'h2, r);
    check_value("add wrap", r, 64'h1);
    check_op(OP_SUB, 64'h3, 64'h5, r);
    check_value("sub below zero", r, 64'hFFFF_FFFF_FFFF_FFFE);
    check_op(OP_AND, 64'hF0F0_1234_5678_9ABC, 64'hFF00_FF00_0FF0_F00F, r);
    check_op(OP_OR,  64'hF0F0_1234_5678_9ABC, 64'hFF00_FF00_0FF0_F00F, r);
    check_op(OP_XOR, 64'hF0F0_1234_5678_9ABC, 64'hFF00_FF00_0FF0_F00F, r);
    check_op(OP_SLTS, 64'h8000_0000_0000_0000, 64'h1, r);
    check_value("slts of min against 1", r, 64'h1);
    check_op(OP_SLTU, 64'h8000_0000_0000_0000, 64'h1, r);
    check_value("sltu of min against 1", r, 64'h0);
endtask

task automatic ldpc_edge_lanes();
    logic [XLEN-1:0] a0;
    logic [XLEN-1:0] b0;
    logic [XLEN-1:0] a1;
    logic [XLEN-1:0] b1;
    logic [XLEN-1:0] r;
    int              k;
    // Lane 7 is 100 and 100, lane 6 is -100 and 100, lane 0 holds 0x80
    a0 = 64'h64_9C_7F_81_00_05_FF_80;
    b0 = 64'h64_64_7F_01_FB_00_80_05;
    a1 = 64'h00_00_80_7F_C8_38_01_FE;
    b1 = 64'h00_80_80_81_38_C8_01_02;
    for (k = LDPC_SUBSAT; k <= LDPC_NMESS; k++) begin
        check_op(alu_op_e'(k), a0, b0, r);
        check_op(alu_op_e'(k), a1, b1, r);
    end
    run_op(LDPC_ADDSAT, a0, b0, r);
    check_value("addsat lane 7", XLEN'(r[63:56]), 64'h7F);
    run_op(LDPC_SUBSAT, a0, b0, r);
    check_value("subsat lane 6", XLEN'(r[55:48]), 64'h81);
    run_op(LDPC_ABS, a0, b0, r);
    check_value("abs lane 0", XLEN'(r[7:0]), 64'h80);
endtask

task automatic random_operations();
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    repeat (200) begin
        op = alu_op_e'(4'($random(seed)));
        a  = {$random(seed), $random(seed)};
        b  = {$random(seed), $random(seed)};
        check_op(op, a, b, r);
    end
endtask

task automatic cmd_back_pressure();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] unused;
    logic [XLEN-1:0] r;
    int              cycles;
    a = 64'h1122_3344_8899_AABB;
    b = 64'h0102_F0F1_7F80_00FF;
    wb_write(ADDR_OPA, a);
    wb_write(ADDR_OPB, b);
    bus_cycle(1'b1, ADDR_CMD, XLEN'(OP_ADD), unused, cycles);
    check_value("first CMD ack latency", XLEN'(cycles), 64'h1);
    // First result lands two cycles after its ack and the stall adds one cycle
    bus_cycle(1'b1, ADDR_CMD, XLEN'(LDPC_MIN), unused, cycles);
    if (cycles < 2) begin
        abort_run("Second CMD write was acknowledged before the first result was ready");
    end
    wb_read(ADDR_RESULT, r);
    check_value("result after back-pressure", r, alu_model(LDPC_MIN, a, b));
endtask

`endif

// ==== testbench/tb_ldpc_alu.sv ====
// Testbench for the LDPC ALU driving the Wishbone slave through directed and random tests
`timescale 1ns/100ps

module tb_ldpc_alu import ldpc_alu_pkg::*; ();

    // ------------------------------
    // Timing
    // ------------------------------
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int DRIVE_DELAY   = 2;
    localparam int SAMPLE_DELAY  = 1;
    localparam int MAX_OPS       = 300;
    localparam int CYCLES_PER_OP = 30;
    // Whole run budget of reset plus every operation at its worst case
    localparam int TIMEOUT_NS    = (RESET_CYCLES + MAX_OPS * CYCLES_PER_OP) * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    integer  seed;

    ldpc_alu_top dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    `include "tb_ldpc_alu_tasks.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        abort_run("Run timed out before all tests finished");
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        seed   = 89;
        rst_n  = 1'b0;
        wb_req = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        @(posedge clk);
        #(DRIVE_DELAY);

        idle_after_reset();
        operand_readback();
        scalar_vectors();
        ldpc_edge_lanes();
        random_operations();
        cmd_back_pressure();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== verilog/ldpc_alu_top.sv ====
// LDPC ALU top level, Wishbone slave in front of a three-stage pipeline
`timescale 1ns/100ps

module ldpc_alu_top import ldpc_alu_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    issue_t          issue;
    exec_t           exec;
    logic [XLEN-1:0] lanes;
    logic            result_valid;
    logic [XLEN-1:0] result_data;
    logic            result_clear;

    wb_issue_stage u_issue (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wb_req_i       (wb_req_i),
        .wb_rsp_o       (wb_rsp_o),
        .result_valid_i (result_valid),
        .result_data_i  (result_data),
        .result_clear_o (result_clear),
        .issue_o        (issue)
    );

    int_exec_stage u_int_exec (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .issue_i (issue),
        .exec_o  (exec)
    );

    ldpc_simd_exec u_ldpc_exec (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .issue_i (issue),
        .lanes_o (lanes)
    );

    result_stage u_result (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .exec_i         (exec),
        .lanes_i        (lanes),
        .result_clear_i (result_clear),
        .result_valid_o (result_valid),
        .result_data_o  (result_data)
    );

endmodule

// ==== verilog/result_stage.sv ====
// Result stage, selects scalar or lane result and holds it until read
`timescale 1ns/100ps

module result_stage import ldpc_alu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  exec_t           exec_i,
    input  logic [XLEN-1:0] lanes_i,
    input  logic            result_clear_i,
    output logic            result_valid_o,
    output logic [XLEN-1:0] result_data_o
);

    logic            valid_q;
    logic [XLEN-1:0] data_q;

    // ------------------------------
    // Completion tracking
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (exec_i.valid) begin
            valid_q <= 1'b1;
        end else if (result_clear_i) begin
            valid_q <= 1'b0;
        end
    end

    // Both execute units register on the same edge
    always_ff @(posedge clk_i) begin
        if (exec_i.valid) begin
            data_q <= exec_i.ldpc_sel ? lanes_i : exec_i.int_result;
        end
    end

    assign result_valid_o = valid_q;
    assign result_data_o  = data_q;

    // Issue must have retired the previous result first
    no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exec_i.valid |-> !valid_q);

endmodule

// ==== verilog/int_exec_stage.sv ====
// Scalar execute stage: add, sub, bitwise logic and set-less-than
`timescale 1ns/100ps

module int_exec_stage import ldpc_alu_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  issue_t issue_i,
    output exec_t  exec_o
);

    logic            sub_op;
    logic            sgn;
    logic            less;
    logic [XLEN-1:0] b_neg;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] int_res;
    logic            valid_q;
    logic            sel_q;
    logic [XLEN-1:0] result_q;

    // Subtract as a + ~b + 1
    assign sub_op = (issue_i.op == OP_SUB);
    assign b_neg  = issue_i.operand_b ^ {XLEN{sub_op}};
    assign sum    = issue_i.operand_a + b_neg + {{XLEN-1{1'b0}}, sub_op};

    // One comparator, extra top bit picks signed or unsigned
    assign sgn  = (issue_i.op == OP_SLTS);
    assign less = $signed({sgn & issue_i.operand_a[XLEN-1], issue_i.operand_a}) <
                  $signed({sgn & issue_i.operand_b[XLEN-1], issue_i.operand_b});

    always_comb begin
        case (issue_i.op)
            OP_ADD, OP_SUB:   int_res = sum;
            OP_AND:           int_res = issue_i.operand_a & issue_i.operand_b;
            OP_OR:            int_res = issue_i.operand_a | issue_i.operand_b;
            OP_XOR:           int_res = issue_i.operand_a ^ issue_i.operand_b;
            OP_SLTS, OP_SLTU: int_res = {{XLEN-1{1'b0}}, less};
            default:          int_res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i.valid) begin
            sel_q    <= (issue_i.op >= LDPC_SUBSAT);
            result_q <= int_res;
        end
    end

    assign exec_o = '{valid: valid_q, ldpc_sel: sel_q, int_result: result_q};

endmodule

// ==== verilog/wb_issue_stage.sv ====
// Wishbone classic slave holding the operands and issuing commands to the pipeline
`timescale 1ns/100ps

module wb_issue_stage import ldpc_alu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  wb_req_t         wb_req_i,
    output wb_rsp_t         wb_rsp_o,
    input  logic            result_valid_i,
    input  logic [XLEN-1:0] result_data_i,
    output logic            result_clear_o,
    output issue_t          issue_o
);

    logic            req;
    logic            ready;
    logic            ack_d;
    logic            ack_q;
    logic            busy_q;
    logic            cmd_accept;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] rdata_q;
    logic [XLEN-1:0] opa_q;
    logic [XLEN-1:0] opb_q;
    logic            issue_valid_q;
    alu_op_e         issue_op_q;
    logic [XLEN-1:0] issue_a_q;
    logic [XLEN-1:0] issue_b_q;

    assign req = wb_req_i.cyc && wb_req_i.stb;

    // ------------------------------
    // Address decode and stall
    // ------------------------------
    always_comb begin
        ready = 1'b1;
        rdata = '0;
        case (wb_req_i.adr)
            ADDR_OPA: rdata = opa_q;
            ADDR_OPB: rdata = opb_q;
            ADDR_CMD: begin
                // Hold off a new command until the current one has a result
                if (wb_req_i.we) begin
                    ready = !busy_q || result_valid_i;
                end
            end
            ADDR_RESULT: begin
                rdata = result_data_i;
                if (!wb_req_i.we) begin
                    ready = result_valid_i;
                end
            end
            default: ;
        endcase
    end

    // Second cycle of an acked request is the master's turnaround
    assign ack_d      = req && !ack_q && ready;
    assign cmd_accept = ack_d && wb_req_i.we && (wb_req_i.adr == ADDR_CMD);

    // A new command also retires any unread result
    assign result_clear_o = cmd_accept ||
                            (ack_d && !wb_req_i.we && (wb_req_i.adr == ADDR_RESULT));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q         <= 1'b0;
            busy_q        <= 1'b0;
            issue_valid_q <= 1'b0;
            opa_q         <= '0;
            opb_q         <= '0;
        end else begin
            ack_q         <= ack_d;
            issue_valid_q <= cmd_accept;
            if (cmd_accept) begin
                busy_q <= 1'b1;
            end else if (result_valid_i) begin
                busy_q <= 1'b0;
            end
            if (ack_d && wb_req_i.we && (wb_req_i.adr == ADDR_OPA)) begin
                opa_q <= wb_req_i.dat;
            end
            if (ack_d && wb_req_i.we && (wb_req_i.adr == ADDR_OPB)) begin
                opb_q <= wb_req_i.dat;
            end
        end
    end

    // Read data and issued command
    always_ff @(posedge clk_i) begin
        if (ack_d) begin
            rdata_q <= rdata;
        end
        if (cmd_accept) begin
            issue_op_q <= alu_op_e'(wb_req_i.dat[3:0]);
            issue_a_q  <= opa_q;
            issue_b_q  <= opb_q;
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};
    assign issue_o  = '{valid: issue_valid_q, op: issue_op_q,
                        operand_a: issue_a_q, operand_b: issue_b_q};

    // ------------------------------
    // Bus protocol checks
    // ------------------------------
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_q |-> req);

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_q |=> !ack_q);

endmodule

// ==== ldpc/ldpc_simd_exec.sv ====
// LDPC SIMD execute stage, eight lanes over the 64-bit operands
`timescale 1ns/100ps

module ldpc_simd_exec import ldpc_alu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  issue_t          issue_i,
    output logic [XLEN-1:0] lanes_o
);

    logic [XLEN-1:0] lanes_d;
    logic [XLEN-1:0] lanes_q;

    // Lane i covers bits i*8 +: 8 of both operands
    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        ldpc_lane u_lane (
            .op_i  (issue_i.op),
            .a_i   (issue_i.operand_a[i*LANE_W +: LANE_W]),
            .b_i   (issue_i.operand_b[i*LANE_W +: LANE_W]),
            .res_o (lanes_d[i*LANE_W +: LANE_W])
        );
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lanes_q <= '0;
        end else if (issue_i.valid) begin
            lanes_q <= lanes_d;
        end
    end

    assign lanes_o = lanes_q;

endmodule

// ==== ldpc/ldpc_lane.sv ====
// One signed 8-bit LDPC lane computing the selected check-node operation
`timescale 1ns/100ps

module ldpc_lane import ldpc_alu_pkg::*; (
    input  alu_op_e           op_i,
    input  logic [LANE_W-1:0] a_i,
    input  logic [LANE_W-1:0] b_i,
    output logic [LANE_W-1:0] res_o
);

    logic signed [LANE_W-1:0] a_s;
    logic signed [LANE_W-1:0] b_s;
    logic signed [LANE_W:0]   sum_w;
    logic signed [LANE_W:0]   diff_w;
    logic                     a_ge_b;

    // Clamp a 9-bit result to +/-SAT_MAX
    function automatic logic [LANE_W-1:0] clamp(input logic signed [LANE_W:0] v);
        logic signed [LANE_W:0] hi;
        logic [LANE_W-1:0]      r;
        hi = (LANE_W+1)'(SAT_MAX);
        if (v > hi) begin
            r = hi[LANE_W-1:0];
        end else if (v < -hi) begin
            r = LANE_W'(-hi);
        end else begin
            r = v[LANE_W-1:0];
        end
        return r;
    endfunction

    assign a_s    = a_i;
    assign b_s    = b_i;
    // One extra bit so overflow is visible before clamping
    assign sum_w  = a_s + b_s;
    assign diff_w = a_s - b_s;
    assign a_ge_b = (a_s >= b_s);

    always_comb begin
        case (op_i)
            LDPC_SUBSAT: res_o = clamp(diff_w);
            LDPC_ADDSAT: res_o = clamp(sum_w);
            LDPC_SIGN:   res_o = {{LANE_W-1{1'b0}}, a_i[LANE_W-1]};
            // 0x80 wraps back onto itself
            LDPC_ABS:    res_o = a_i[LANE_W-1] ? -a_i : a_i;
            // Ties go to a for max, b for min
            LDPC_MAX:    res_o = a_ge_b ? a_i : b_i;
            LDPC_MIN:    res_o = a_ge_b ? b_i : a_i;
            LDPC_EVAL:   res_o = (a_i == b_i) ? {LANE_W{1'b1}} : {LANE_W{1'b0}};
            LDPC_RSIGN:  res_o = a_i ^ {{LANE_W-1{1'b0}}, ~b_i[LANE_W-1]};
            LDPC_NMESS:  res_o = (a_i != '0) ? b_i : -b_i;
            default:     res_o = '0;
        endcase
    end

endmodule

// ==== common/ldpc_alu_pkg.sv ====
// LDPC ALU shared definitions: widths, register map, opcodes and pipeline structs
package ldpc_alu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN    = 64;
    localparam int LANE_W  = 8;
    localparam int LANES   = XLEN / LANE_W;
    // Saturation is symmetric, -128 never produced
    localparam int SAT_MAX = 127;
    localparam int ADDR_W  = 2;

    // Word addresses of the register map
    localparam logic [ADDR_W-1:0] ADDR_OPA    = 2'd0;
    localparam logic [ADDR_W-1:0] ADDR_OPB    = 2'd1;
    localparam logic [ADDR_W-1:0] ADDR_CMD    = 2'd2;
    localparam logic [ADDR_W-1:0] ADDR_RESULT = 2'd3;

    // ------------------------------
    // Opcodes
    // ------------------------------
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLTS, OP_SLTU,
        LDPC_SUBSAT, LDPC_ADDSAT, LDPC_SIGN, LDPC_ABS,
        LDPC_MAX, LDPC_MIN, LDPC_EVAL, LDPC_RSIGN, LDPC_NMESS
    } alu_op_e;

    // ------------------------------
    // Bus and pipeline payloads
    // ------------------------------
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [XLEN-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        logic [XLEN-1:0] operand_a;
        logic [XLEN-1:0] operand_b;
    } issue_t;

    typedef struct packed {
        logic            valid;
        logic            ldpc_sel;
        logic [XLEN-1:0] int_result;
    } exec_t;

endpackage
